// ==== design/mcore_defs.svh ====
/* message field widths, shared memory depth and word index width */

`ifndef MCORE_DEFS_SVH
`define MCORE_DEFS_SVH

// ====================
// message fields

`define MCORE_OPAQUE_NBITS 8
`define MCORE_ADDR_NBITS 32
`define MCORE_DATA_NBITS 32

// ====================
// shared memory

`define MCORE_MEM_WORDS 64
// word index is address bits 7:2
`define MCORE_WORD_IDX_NBITS 6

`endif

// ==== design/mcore_mem_sys.sv ====
`timescale 1ns/1ps
/* shared memory system top
   network, domain-tagged memory, one response access control per port */

module mcore_mem_sys (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   mem_clear,

	input  mem_msg_pkg::mem_req_t  req0_msg,
	input  logic                   req0_val,
	output logic                   req0_rdy,

	input  mem_msg_pkg::mem_req_t  req1_msg,
	input  logic                   req1_val,
	output logic                   req1_rdy,

	output mem_msg_pkg::mem_resp_t resp0_msg,
	output logic                   resp0_val,
	input  logic                   resp0_rdy,

	output mem_msg_pkg::mem_resp_t resp1_msg,
	output logic                   resp1_val,
	input  logic                   resp1_rdy
);
	import sec_pkg::*;

	sec_req_t  mem_req_msg;
	logic      mem_req_val;
	logic      mem_req_rdy;
	sec_resp_t mem_resp_msg;
	logic      mem_resp_val;
	logic      mem_resp_rdy;
	sec_resp_t net_resp0_msg;
	logic      net_resp0_val;
	logic      net_resp0_rdy;
	sec_resp_t net_resp1_msg;
	logic      net_resp1_val;
	logic      net_resp1_rdy;

	// every network port has a same-named wire or top port
	mem_net u_mem_net (.*);

	test_mem u_test_mem (
		.clk       (clk),
		.arst_n    (arst_n),
		.mem_clear (mem_clear),
		.req_msg   (mem_req_msg),
		.req_val   (mem_req_val),
		.req_rdy   (mem_req_rdy),
		.resp_msg  (mem_resp_msg),
		.resp_val  (mem_resp_val),
		.resp_rdy  (mem_resp_rdy)
	);

	// port 0 is the low domain, port 1 the high domain
	resp_acc #(.p_level(DOM_LOW)) resp_acc0 (
		.net_resp_msg  (net_resp0_msg),
		.net_resp_val  (net_resp0_val),
		.net_resp_rdy  (net_resp0_rdy),
		.proc_resp_msg (resp0_msg),
		.proc_resp_val (resp0_val),
		.proc_resp_rdy (resp0_rdy)
	);

	resp_acc #(.p_level(DOM_HIGH)) resp_acc1 (
		.net_resp_msg  (net_resp1_msg),
		.net_resp_val  (net_resp1_val),
		.net_resp_rdy  (net_resp1_rdy),
		.proc_resp_msg (resp1_msg),
		.proc_resp_val (resp1_val),
		.proc_resp_rdy (resp1_rdy)
	);

endmodule

// ==== design/mem_msg_pkg.sv ====
/* memory message types
   opcode enum, request and response structs */

`include "mcore_defs.svh"

package mem_msg_pkg;

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_type_e;

	// 73 bits
	typedef struct packed {
		mem_type_e                      op;
		logic [`MCORE_OPAQUE_NBITS-1:0] opaque;
		logic [`MCORE_ADDR_NBITS-1:0]   addr;
		logic [`MCORE_DATA_NBITS-1:0]   data;
	} mem_req_t;

	// 41 bits, opcode and opaque echo the request
	typedef struct packed {
		mem_type_e                      op;
		logic [`MCORE_OPAQUE_NBITS-1:0] opaque;
		logic [`MCORE_DATA_NBITS-1:0]   data;
	} mem_resp_t;

endpackage

// ==== design/mem_net.sv ====
`timescale 1ns/1ps
/* two-port memory network
   round-robin request grant, domain tagging, response steering */

module mem_net (
	input  logic                   clk,
	input  logic                   arst_n,

	input  mem_msg_pkg::mem_req_t  req0_msg,
	input  logic                   req0_val,
	output logic                   req0_rdy,

	input  mem_msg_pkg::mem_req_t  req1_msg,
	input  logic                   req1_val,
	output logic                   req1_rdy,

	output sec_pkg::sec_req_t      mem_req_msg,
	output logic                   mem_req_val,
	input  logic                   mem_req_rdy,

	input  sec_pkg::sec_resp_t     mem_resp_msg,
	input  logic                   mem_resp_val,
	output logic                   mem_resp_rdy,

	output sec_pkg::sec_resp_t     net_resp0_msg,
	output logic                   net_resp0_val,
	input  logic                   net_resp0_rdy,

	output sec_pkg::sec_resp_t     net_resp1_msg,
	output logic                   net_resp1_val,
	input  logic                   net_resp1_rdy
);
	import sec_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} state_e;

	state_e state;
	logic   last_grant;
	logic   src_port;
	logic   grant_sel;
	logic   idle;
	logic   req_go;
	logic   resp_go;

	// ====================
	// request side

	assign idle = (state == ST_IDLE);

	// on a tie the port that lost last time wins
	assign grant_sel = (req0_val && req1_val) ? ~last_grant : req1_val;

	always_comb begin
		mem_req_msg.req    = grant_sel ? req1_msg : req0_msg;
		mem_req_msg.domain = grant_sel ? DOM_HIGH : DOM_LOW;
	end

	assign mem_req_val = idle && (req0_val || req1_val);
	assign req0_rdy    = idle && req0_val && !grant_sel && mem_req_rdy;
	assign req1_rdy    = idle && req1_val && grant_sel && mem_req_rdy;
	assign req_go      = mem_req_val && mem_req_rdy;

	// ====================
	// response side

	assign net_resp0_msg = mem_resp_msg;
	assign net_resp1_msg = mem_resp_msg;
	assign net_resp0_val = !idle && mem_resp_val && !src_port;
	assign net_resp1_val = !idle && mem_resp_val && src_port;
	assign mem_resp_rdy  = !idle && (src_port ? net_resp1_rdy : net_resp0_rdy);
	assign resp_go       = mem_resp_val && mem_resp_rdy;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ST_IDLE;
			last_grant <= 1'b1;
			src_port   <= 1'b0;
		end else if (idle && req_go) begin
			state      <= ST_BUSY;
			last_grant <= grant_sel;
			src_port   <= grant_sel;
		end else if (!idle && resp_go) begin
			state <= ST_IDLE;
		end
	end

endmodule

// ==== design/resp_acc.sv ====
`timescale 1ns/1ps
/* response access control for one client port
   zeroes data from a higher domain and strips the domain tag */

module resp_acc #(
	parameter sec_pkg::domain_e p_level = sec_pkg::DOM_LOW
) (
	input  sec_pkg::sec_resp_t     net_resp_msg,
	input  logic                   net_resp_val,
	output logic                   net_resp_rdy,

	output mem_msg_pkg::mem_resp_t proc_resp_msg,
	output logic                   proc_resp_val,
	input  logic                   proc_resp_rdy
);

	logic hide;

	// word belongs to a domain above this port
	assign hide = (net_resp_msg.domain > p_level);

	always_comb begin
		proc_resp_msg = net_resp_msg.resp;
		if (hide) begin
			proc_resp_msg.data = '0;
		end
	end

	// handshake passes straight through
	assign proc_resp_val = net_resp_val;
	assign net_resp_rdy  = proc_resp_rdy;

endmodule

// ==== design/sec_pkg.sv ====
/* security domain enum and domain-tagged memory messages */

package sec_pkg;

	import mem_msg_pkg::*;

	typedef enum logic {
		DOM_LOW  = 1'b0,
		DOM_HIGH = 1'b1
	} domain_e;

	typedef struct packed {
		mem_req_t req;
		domain_e  domain;
	} sec_req_t;

	// domain of the word that was read or written
	typedef struct packed {
		mem_resp_t resp;
		domain_e   domain;
	} sec_resp_t;

endpackage

// ==== design/test_mem.sv ====
`timescale 1ns/1ps
/* shared word memory with a domain tag per word
   one-entry response register, level clear */

`include "mcore_defs.svh"

module test_mem (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               mem_clear,

	input  sec_pkg::sec_req_t  req_msg,
	input  logic               req_val,
	output logic               req_rdy,

	output sec_pkg::sec_resp_t resp_msg,
	output logic               resp_val,
	input  logic               resp_rdy
);
	import mem_msg_pkg::*;
	import sec_pkg::*;

	logic [`MCORE_DATA_NBITS-1:0]     data_mem [`MCORE_MEM_WORDS];
	domain_e                          tag_mem [`MCORE_MEM_WORDS];
	logic [`MCORE_WORD_IDX_NBITS-1:0] idx;
	logic                             is_write;
	logic                             accept;
	logic                             clear_en;

	assign idx      = req_msg.req.addr[`MCORE_WORD_IDX_NBITS+1:2];
	assign is_write = (req_msg.req.op == MEM_WRITE);

	// no new request while a response is held or a clear is asked for
	assign req_rdy  = !resp_val && !mem_clear;
	assign accept   = req_val && req_rdy;
	assign clear_en = mem_clear && !resp_val;

	// ====================
	// storage

	always_ff @(posedge clk) begin
		if (clear_en) begin
			for (int i = 0; i < `MCORE_MEM_WORDS; i++) begin
				data_mem[i] <= '0;
				tag_mem[i]  <= DOM_LOW;
			end
		end else if (accept && is_write) begin
			data_mem[idx] <= req_msg.req.data;
			tag_mem[idx]  <= req_msg.domain;
		end
	end

	// ====================
	// response register

	always_ff @(posedge clk) begin
		if (accept) begin
			resp_msg.resp.op     <= req_msg.req.op;
			resp_msg.resp.opaque <= req_msg.req.opaque;
			resp_msg.resp.data   <= is_write ? '0 : data_mem[idx];
			resp_msg.domain      <= is_write ? req_msg.domain : tag_mem[idx];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			resp_val <= 1'b0;
		end else if (accept) begin
			resp_val <= 1'b1;
		end else if (resp_rdy) begin
			resp_val <= 1'b0;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the shared memory system testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_mcore_mem_sys -o tb_mcore_mem_sys
./obj_dir/tb_mcore_mem_sys > sim.log 2>&1
cat sim.log

if grep -qx "Verification passed" sim.log; then
	exit 0
else
	exit 1
fi

// ==== sources.f ====
+incdir+design
design/mem_msg_pkg.sv
design/sec_pkg.sv
design/mem_net.sv
design/resp_acc.sv
design/test_mem.sv
design/mcore_mem_sys.sv
verif/tb_mcore_mem_sys.sv

// ==== verif/tb_mcore_mem_sys.sv ====
`timescale 1ns/1ps
/* testbench for the shared memory system
   reference model, directed tests, compare tasks and watchdog */

`include "mcore_defs.svh"

module tb_mcore_mem_sys;
	import mem_msg_pkg::*;
	import sec_pkg::*;

	localparam int clk_period = 20;
	localparam int n_tests = 6;
	localparam int test_cycles = 400;
	localparam int n_burst = 8;

	logic            clk;
	logic            arst_n;
	logic            mem_clear;
	mem_req_t  [1:0] req_msg;
	mem_resp_t [1:0] resp_msg;
	logic      [1:0] req_val;
	logic      [1:0] req_rdy;
	logic      [1:0] resp_val;
	logic      [1:0] resp_rdy;

	// reference model of the shared memory
	logic [`MCORE_DATA_NBITS-1:0] model_data [`MCORE_MEM_WORDS];
	domain_e                      model_tag [`MCORE_MEM_WORDS];
	mem_req_t                     burst_reqs [2][n_burst];

	int errors;
	int checks;
	int tests;
	int resp_order [$];

	mcore_mem_sys u_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.mem_clear (mem_clear),
		.req0_msg  (req_msg[0]),
		.req0_val  (req_val[0]),
		.req0_rdy  (req_rdy[0]),
		.req1_msg  (req_msg[1]),
		.req1_val  (req_val[1]),
		.req1_rdy  (req_rdy[1]),
		.resp0_msg (resp_msg[0]),
		.resp0_val (resp_val[0]),
		.resp0_rdy (resp_rdy[0]),
		.resp1_msg (resp_msg[1]),
		.resp1_val (resp_val[1]),
		.resp1_rdy (resp_rdy[1])
	);

	always #(clk_period / 2) clk = ~clk;

	// ====================
	// compare tasks and model

	task automatic check_resp(input string name, input mem_resp_t got, input mem_resp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	function automatic mem_resp_t model_access(input int p, input mem_req_t req);
		mem_resp_t                        resp;
		logic [`MCORE_WORD_IDX_NBITS-1:0] idx;
		domain_e                          dom;
		idx = req.addr[`MCORE_WORD_IDX_NBITS+1:2];
		dom = (p == 1) ? DOM_HIGH : DOM_LOW;
		resp.op = req.op;
		resp.opaque = req.opaque;
		resp.data = '0;
		if (req.op == MEM_WRITE) begin
			model_data[idx] = req.data;
			model_tag[idx] = dom;
		end else if (!(model_tag[idx] == DOM_HIGH && dom == DOM_LOW)) begin
			resp.data = model_data[idx];
		end
		return resp;
	endfunction

	function automatic mem_req_t make_req(input mem_type_e op, input logic [5:0] idx);
		mem_req_t    req;
		int unsigned r;
		r = $urandom;
		req.op = op;
		req.opaque = r[`MCORE_OPAQUE_NBITS-1:0];
		req.addr = '0;
		req.addr[`MCORE_WORD_IDX_NBITS+1:2] = idx;
		req.data = (op == MEM_WRITE) ? $urandom : '0;
		return req;
	endfunction

	// ====================
	// port drivers, entered and left 1 ns after a rising edge

	task automatic send_req(input int p, input mem_req_t req, output mem_resp_t exp);
		req_msg[p] = req;
		req_val[p] = 1'b1;
		do begin
			@(negedge clk);
		end while (!req_rdy[p]);
		exp = model_access(p, req);
		@(posedge clk);
		#1;
		req_val[p] = 1'b0;
	endtask

	task automatic recv_resp(input int p, input mem_resp_t exp);
		do begin
			@(negedge clk);
		end while (!resp_val[p]);
		check_resp($sformatf("resp%0d_msg", p), resp_msg[p], exp);
		resp_order.push_back(p);
		@(posedge clk);
		#1;
	endtask

	task automatic access(input int p, input mem_req_t req);
		mem_resp_t exp;
		send_req(p, req, exp);
		recv_resp(p, exp);
	endtask

	task automatic clear_memory();
		mem_clear = 1'b1;
		@(posedge clk);
		#1;
		mem_clear = 1'b0;
		for (int i = 0; i < `MCORE_MEM_WORDS; i++) begin
			model_data[i] = '0;
			model_tag[i] = DOM_LOW;
		end
	endtask

	task automatic finish_test(input string name, input int start);
		tests++;
		$display("test %s: %0d errors", name, errors - start);
	endtask

	// ====================
	// directed tests

	task automatic test_reset_idle();
		int start;
		start = errors;
		repeat (4) begin
			@(negedge clk);
			check_bit("resp0_val", resp_val[0], 1'b0);
			check_bit("resp1_val", resp_val[1], 1'b0);
			check_bit("req0_rdy", req_rdy[0], 1'b0);
			check_bit("req1_rdy", req_rdy[1], 1'b0);
		end
		@(posedge clk);
		#1;
		finish_test("reset idle", start);
	endtask

	task automatic run_burst(input int p);
		for (int i = 0; i < n_burst; i++) begin
			access(p, burst_reqs[p][i]);
		end
	endtask

	// must run first after reset, port 0 wins the first tie
	task automatic test_arbitration();
		int          start;
		int unsigned r;
		start = errors;
		for (int i = 0; i < 2 * n_burst; i++) begin
			r = $urandom;
			burst_reqs[i % 2][i / 2] = make_req(r[0] ? MEM_WRITE : MEM_READ, r[6:1]);
		end
		resp_order.delete();
		fork
			run_burst(0);
			run_burst(1);
		join
		checks++;
		foreach (resp_order[i]) begin
			if (resp_order[i] != i % 2) begin
				errors++;
				$display("response %0d went to port %0d out of turn", i, resp_order[i]);
			end
		end
		finish_test("arbitration", start);
	endtask

	task automatic test_write_read();
		int start;
		start = errors;
		for (int p = 0; p < 2; p++) begin
			access(p, make_req(MEM_WRITE, (p == 0) ? 6'd9 : 6'd5));
			access(p, make_req(MEM_READ, (p == 0) ? 6'd9 : 6'd5));
		end
		finish_test("write read", start);
	endtask

	task automatic test_isolation();
		int start;
		start = errors;
		access(1, make_req(MEM_WRITE, 6'd20));
		// high word seen from the low port
		access(0, make_req(MEM_READ, 6'd20));
		access(0, make_req(MEM_WRITE, 6'd21));
		access(1, make_req(MEM_READ, 6'd21));
		access(0, make_req(MEM_WRITE, 6'd20));
		access(0, make_req(MEM_READ, 6'd20));
		finish_test("isolation", start);
	endtask

	task automatic test_backpressure();
		int        start;
		int        n;
		mem_req_t  rq1;
		mem_resp_t exp0;
		mem_resp_t exp1;
		start = errors;
		access(0, make_req(MEM_WRITE, 6'd30));
		rq1 = make_req(MEM_WRITE, 6'd31);
		n = 2 + int'($urandom % 6);
		resp_rdy[0] = 1'b0;
		send_req(0, make_req(MEM_READ, 6'd30), exp0);
		req_msg[1] = rq1;
		req_val[1] = 1'b1;
		repeat (n) begin
			@(negedge clk);
			check_bit("resp0_val", resp_val[0], 1'b1);
			check_resp("resp0_msg", resp_msg[0], exp0);
			check_bit("req1_rdy", req_rdy[1], 1'b0);
		end
		@(posedge clk);
		#1;
		resp_rdy[0] = 1'b1;
		recv_resp(0, exp0);
		send_req(1, rq1, exp1);
		recv_resp(1, exp1);
		finish_test("backpressure", start);
	endtask

	task automatic test_clear();
		int start;
		start = errors;
		access(0, make_req(MEM_WRITE, 6'd40));
		access(1, make_req(MEM_WRITE, 6'd41));
		clear_memory();
		for (int p = 0; p < 2; p++) begin
			access(p, make_req(MEM_READ, 6'd40));
			access(p, make_req(MEM_READ, 6'd41));
		end
		finish_test("clear", start);
	endtask

	// ====================
	// main sequence and watchdog

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		mem_clear = 1'b0;
		req_msg = '0;
		req_val = '0;
		resp_rdy = 2'b11;
		errors = 0;
		checks = 0;
		tests = 0;
		void'($urandom(32'h19279672));
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		test_reset_idle();
		clear_memory();
		test_arbitration();
		test_write_read();
		test_isolation();
		test_backpressure();
		test_clear();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(n_tests * test_cycles * clk_period);
		$display("timeout: tests still running after %0d ns", n_tests * test_cycles * clk_period);
		$display("Verification failed");
		$finish;
	end

endmodule
